/* bcdPkg.sv */
package bcdPkg;

	// **************************************************
	// packed decimal counts
	// **************************************************

	typedef logic [3:0] bcdDigitT; // one decimal digit, 0 to 9

	localparam int NumDigits = 4; // ones, tens, hundreds, thousands

	typedef bcdDigitT [NumDigits-1:0] bcdCountT; // index 3 is the thousands digit

	// digit-wise decimal add, carry out of the thousands digit is dropped
	function automatic bcdCountT bcdAdd(input bcdCountT a, input bcdCountT b);
		bcdCountT result;
		logic carry;
		logic [4:0] digitSum;
		carry = 1'b0;
		for (int i = 0; i < NumDigits; i++) begin
			digitSum = {1'b0, a[i]} + {1'b0, b[i]} + {4'b0, carry};
			carry = (digitSum > 5'd9);
			if (carry) begin
				digitSum = digitSum - 5'd10; // back into 0..9
			end
			result[i] = digitSum[3:0];
		end
		return result;
	endfunction

endpackage

/* gamePkg.sv */
package gamePkg;

	// **************************************************
	// board and mole motion
	// **************************************************

	localparam int NumMoles = 8; // holes on the board
	localparam int HeightMax = 20; // fully raised
	localparam int HeightWidth = 5;
	localparam int WaitCount = 4; // wait strobes spent at the top
	localparam int WaitWidth = $clog2(WaitCount + 1);

	typedef logic [HeightWidth-1:0] heightT;

	// strobe rates in Clock cycles
	localparam int StepPeriod = 2;
	localparam int WaitPeriod = 4;
	localparam int TickWidth = $clog2((StepPeriod > WaitPeriod ? StepPeriod : WaitPeriod) + 1);

	// **************************************************
	// random rise source
	// **************************************************

	localparam int LfsrWidth = 16; // also the seed counter width
	localparam int SlotSpacing = 60; // sequence bits between mole taps
	localparam int SeqLength = NumMoles * SlotSpacing;

	// FSM encodings
	localparam logic [1:0] WhackIdle = 2'b00;
	localparam logic [1:0] WhackPressed = 2'b01;
	localparam logic [1:0] WhackHit = 2'b11;

	localparam logic [1:0] MoleHiding = 2'b00;
	localparam logic [1:0] MoleRising = 2'b01;
	localparam logic [1:0] MoleWaiting = 2'b11;
	localparam logic [1:0] MoleLowering = 2'b10;

endpackage

/* tickGenerator.sv */
`timescale 1ns/10ps

module tickGenerator (
	input logic Clock,
	input logic reset,
	output logic stepTick,
	output logic waitTick
);

	logic [1:0] strobes; // bit 0 step, bit 1 wait

	// one down-counter per strobe, each fires when it reaches zero
	for (genvar t = 0; t < 2; t++) begin : gTick
		logic [gamePkg::TickWidth-1:0] count;
		logic [gamePkg::TickWidth-1:0] reload;

		assign reload = gamePkg::TickWidth'(((t == 0) ? gamePkg::StepPeriod :
			gamePkg::WaitPeriod) - 1); // period minus one

		always_ff @(posedge Clock or posedge reset) begin
			if (reset) begin
				count <= reload;
			end else if (count == '0) begin
				count <= reload; // wrap, strobe is high this cycle
			end else begin
				count <= count - 1'b1;
			end
		end

		assign strobes[t] = (count == '0);
	end

	assign stepTick = strobes[0];
	assign waitTick = strobes[1];

endmodule

/* moleScheduler.sv */
`timescale 1ns/10ps

module moleScheduler (
	input logic Clock,
	input logic reset,
	input logic loadSeed,
	input logic shift,
	output logic [gamePkg::NumMoles-1:0] riseRequest
);

	logic [gamePkg::LfsrWidth-1:0] seedCount; // free running, sampled as the seed
	logic [gamePkg::LfsrWidth-1:0] lfsr;
	logic feedback;
	logic [gamePkg::SeqLength-1:0] seqBits; // long delay line of random bits

	// **************************************************
	// seed source
	// **************************************************

	always_ff @(posedge Clock or posedge reset) begin
		if (reset) begin
			seedCount <= '0;
		end else begin
			seedCount <= seedCount + 1'b1;
		end
	end

	// **************************************************
	// LFSR
	// **************************************************

	assign feedback = lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5];

	always_ff @(posedge Clock or posedge reset) begin
		if (reset) begin
			lfsr <= '0; // stays zero until a seed is loaded
		end else if (loadSeed) begin
			lfsr <= seedCount;
		end else if (shift) begin
			lfsr <= {feedback, lfsr[gamePkg::LfsrWidth-1:1]};
		end
	end

	// **************************************************
	// rise sequence
	// **************************************************

	always_ff @(posedge Clock or posedge reset) begin
		if (reset) begin
			seqBits <= '0;
		end else if (shift) begin
			seqBits <= {seqBits[gamePkg::SeqLength-2:0], lfsr[0]}; // new bit enters at 0
		end
	end

	// each mole taps the last bit of its slot
	for (genvar k = 0; k < gamePkg::NumMoles; k++) begin : gTap
		assign riseRequest[k] = seqBits[(k + 1) * gamePkg::SlotSpacing - 1];
	end

endmodule

/* whackDecoder.sv */
`timescale 1ns/10ps

module whackDecoder (
	input logic Clock,
	input logic reset,
	input logic [gamePkg::NumMoles-1:0] switches,
	output logic [gamePkg::NumMoles-1:0] hit
);

	// press then release on a switch gives a single hit strobe
	for (genvar m = 0; m < gamePkg::NumMoles; m++) begin : gSwitch
		logic [1:0] state;
		logic [1:0] nextState;

		always_comb begin
			nextState = state;
			case (state)
				gamePkg::WhackIdle: begin
					if (switches[m]) nextState = gamePkg::WhackPressed;
				end
				gamePkg::WhackPressed: begin
					if (!switches[m]) nextState = gamePkg::WhackHit; // released
				end
				gamePkg::WhackHit: begin
					nextState = gamePkg::WhackIdle; // strobe lasts one cycle
				end
				default: begin
					nextState = gamePkg::WhackIdle;
				end
			endcase
		end

		always_ff @(posedge Clock or posedge reset) begin
			if (reset) begin
				state <= gamePkg::WhackIdle;
			end else begin
				state <= nextState;
			end
		end

		assign hit[m] = (state == gamePkg::WhackHit);
	end

endmodule

/* moleRiser.sv */
`timescale 1ns/10ps

module moleRiser (
	input logic Clock,
	input logic reset,
	input logic stepTick,
	input logic waitTick,
	input logic go,
	input logic hit,
	output gamePkg::heightT height,
	output logic hiding
);

	logic [1:0] state;
	logic [gamePkg::WaitWidth-1:0] waitCount; // wait strobes seen at the top

	// **************************************************
	// rise, wait and lower controller
	// **************************************************

	always_ff @(posedge Clock or posedge reset) begin
		if (reset) begin
			state <= gamePkg::MoleHiding;
			height <= '0;
			waitCount <= '0;
		end else if (hit) begin
			// a whack drops the mole straight back into its hole
			state <= gamePkg::MoleHiding;
			height <= '0;
			waitCount <= '0;
		end else begin
			case (state)
				gamePkg::MoleHiding: begin
					if (go) begin
						state <= gamePkg::MoleRising;
					end
				end
				gamePkg::MoleRising: begin
					if (height == gamePkg::HeightMax) begin
						state <= gamePkg::MoleWaiting; // fully up
					end else if (stepTick) begin
						height <= height + 1'b1;
					end
				end
				gamePkg::MoleWaiting: begin
					if (waitCount == gamePkg::WaitCount) begin
						state <= gamePkg::MoleLowering;
						waitCount <= '0;
					end else if (waitTick) begin
						waitCount <= waitCount + 1'b1;
					end
				end
				gamePkg::MoleLowering: begin
					if (height == '0) begin
						state <= gamePkg::MoleHiding; // back down, cycle done
					end else if (stepTick) begin
						height <= height - 1'b1;
					end
				end
				default: begin
					state <= gamePkg::MoleHiding;
				end
			endcase
		end
	end

	assign hiding = (state == gamePkg::MoleHiding);

endmodule

/* scoreTally.sv */
`timescale 1ns/10ps

module scoreTally (
	input logic Clock,
	input logic reset,
	input logic [gamePkg::NumMoles-1:0] hit,
	input logic [gamePkg::NumMoles-1:0] hiding,
	input logic [gamePkg::NumMoles-1:0] riseRequest,
	output bcdPkg::bcdCountT totalScore,
	output bcdPkg::bcdCountT totalRise
);

	wire bcdPkg::bcdCountT [gamePkg::NumMoles-1:0] hitCounts; // per mole scores
	wire bcdPkg::bcdCountT [gamePkg::NumMoles-1:0] riseCounts; // per mole rises

	// **************************************************
	// per mole decimal counters
	// **************************************************

	for (genvar m = 0; m < gamePkg::NumMoles; m++) begin : gMole
		bcdPkg::bcdCountT hitCount;
		bcdPkg::bcdCountT riseCount;

		always_ff @(posedge Clock or posedge reset) begin
			if (reset) begin
				hitCount <= '0;
			end else if (hit[m] && !hiding[m]) begin
				// only a mole that is up can be scored
				hitCount <= bcdPkg::bcdAdd(hitCount, bcdPkg::bcdCountT'(1));
			end
		end

		always_ff @(posedge Clock or posedge reset) begin
			if (reset) begin
				riseCount <= '0;
			end else if (riseRequest[m] && hiding[m]) begin
				riseCount <= bcdPkg::bcdAdd(riseCount, bcdPkg::bcdCountT'(1)); // leaves hole now
			end
		end

		assign hitCounts[m] = hitCount;
		assign riseCounts[m] = riseCount;
	end

	// **************************************************
	// totals
	// **************************************************

	// chained decimal adds, mole 0 first
	always_comb begin
		totalScore = '0;
		totalRise = '0;
		for (int m = 0; m < gamePkg::NumMoles; m++) begin
			totalScore = bcdPkg::bcdAdd(totalScore, hitCounts[m]);
			totalRise = bcdPkg::bcdAdd(totalRise, riseCounts[m]);
		end
	end

endmodule

/* whackGame.sv */
`timescale 1ns/10ps

module whackGame (
	input logic Clock,
	input logic reset,
	input logic [gamePkg::NumMoles-1:0] switches,
	input logic loadSeed,
	input logic shift,
	output gamePkg::heightT [gamePkg::NumMoles-1:0] moleHeights,
	output bcdPkg::bcdCountT totalScore,
	output bcdPkg::bcdCountT totalRise
);

	logic stepTick;
	logic waitTick;
	logic [gamePkg::NumMoles-1:0] riseRequest;
	logic [gamePkg::NumMoles-1:0] hit;
	logic [gamePkg::NumMoles-1:0] hiding;

	tickGenerator i_tickGenerator (
		.Clock(Clock),
		.reset(reset),
		.stepTick(stepTick),
		.waitTick(waitTick)
	);

	moleScheduler i_moleScheduler (
		.Clock(Clock),
		.reset(reset),
		.loadSeed(loadSeed),
		.shift(shift),
		.riseRequest(riseRequest)
	);

	whackDecoder i_whackDecoder (
		.Clock(Clock),
		.reset(reset),
		.switches(switches),
		.hit(hit)
	);

	// one controller per hole
	for (genvar m = 0; m < gamePkg::NumMoles; m++) begin : gMole
		moleRiser i_moleRiser (
			.Clock(Clock),
			.reset(reset),
			.stepTick(stepTick),
			.waitTick(waitTick),
			.go(riseRequest[m]),
			.hit(hit[m]),
			.height(moleHeights[m]),
			.hiding(hiding[m])
		);
	end

	scoreTally i_scoreTally (
		.Clock(Clock),
		.reset(reset),
		.hit(hit),
		.hiding(hiding),
		.riseRequest(riseRequest),
		.totalScore(totalScore),
		.totalRise(totalRise)
	);

endmodule

/* tbWhackGame.sv */
`timescale 1ns/10ps

module tbWhackGame;

	localparam int ResetCycles = 2;
	localparam int ZeroPhaseCycles = 600; // longer than the rise sequence
	localparam int SeedDelayMax = 64;
	localparam int PlayMinCycles = 800;
	localparam int PlayBudget = 3000;
	localparam int QuietBudget = 3000; // search for a cycle with every tap clear
	localparam int SettleBudget = 300;
	localparam int Margin = 200;
	localparam int CycleLimit = ResetCycles + ZeroPhaseCycles + SeedDelayMax + PlayBudget +
		QuietBudget + SettleBudget + Margin;
	localparam int ScoreTarget = 12; // enough to carry into the tens digit
	localparam int WhackMinHeight = 5;

	logic Clock;
	logic reset;
	logic [gamePkg::NumMoles-1:0] switches;
	logic loadSeed;
	logic shift;
	gamePkg::heightT [gamePkg::NumMoles-1:0] moleHeights;
	bcdPkg::bcdCountT totalScore;
	bcdPkg::bcdCountT totalRise;

	logic [31:0] lcgState;
	int cycleCount;
	int riseSeen; // 0 to 1 height steps seen
	int scoreModel; // scored whacks in decimal
	logic zeroPhase;
	logic [gamePkg::NumMoles-1:0] dropOk; // a whack may drop this height to 0
	gamePkg::heightT [gamePkg::NumMoles-1:0] prevHeights;

	// scheduler model, used only to find a moment with no rise request
	logic [gamePkg::LfsrWidth-1:0] seedModel;
	logic [gamePkg::LfsrWidth-1:0] lfsrModel;
	logic [gamePkg::SeqLength-1:0] seqModel;

	whackGame i_whackGame (
		.Clock(Clock),
		.reset(reset),
		.switches(switches),
		.loadSeed(loadSeed),
		.shift(shift),
		.moleHeights(moleHeights),
		.totalScore(totalScore),
		.totalRise(totalRise)
	);

	initial begin
		Clock = 1'b0;
		forever #20 Clock = ~Clock;
	end

	// **************************************************
	// helpers
	// **************************************************

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic bcdPkg::bcdCountT toBcd(input int value);
		bcdPkg::bcdCountT result;
		int rest;
		rest = value;
		for (int i = 0; i < bcdPkg::NumDigits; i++) begin
			result[i] = bcdPkg::bcdDigitT'(rest % 10);
			rest = rest / 10;
		end
		return result;
	endfunction

	function automatic logic digitsValid(input bcdPkg::bcdCountT count);
		for (int i = 0; i < bcdPkg::NumDigits; i++) begin
			if (count[i] > 4'd9) return 1'b0;
		end
		return 1'b1;
	endfunction

	function automatic int pickTarget(input int start);
		int idx;
		for (int i = 0; i < gamePkg::NumMoles; i++) begin
			idx = (start + i) % gamePkg::NumMoles;
			if (moleHeights[idx] >= WhackMinHeight) return idx;
		end
		return -1; // nobody high enough
	endfunction

	function automatic logic tapsClear();
		logic anySet;
		anySet = 1'b0;
		for (int k = 0; k < gamePkg::NumMoles; k++) begin
			anySet = anySet | seqModel[(k + 1) * gamePkg::SlotSpacing - 1];
		end
		return !anySet;
	endfunction

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("TEST FAILED");
		$display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, expected);
		$fatal(1);
	endtask

	task automatic stopWithReason(input string reason);
		$display("TEST FAILED");
		$display("%s at %0t", reason, $time);
		$fatal(1);
	endtask

	task automatic nextDrive();
		@(posedge Clock);
		#2;
	endtask

	// press, hold, release, then check the response two edges after the release
	task automatic whackHole(input int m);
		int hold;
		logic [31:0] r;
		gamePkg::heightT heightAtHit;
		r = nextRandom();
		hold = 1 + int'(r[31]);
		switches[m] = 1'b1;
		repeat (hold) nextDrive();
		switches[m] = 1'b0;
		dropOk[m] = 1'b1;
		@(posedge Clock); // release sampled
		@(negedge Clock);
		heightAtHit = moleHeights[m];
		@(posedge Clock); // hit acts
		@(negedge Clock);
		assert (moleHeights[m] == '0)
			else reportMismatch($sformatf("moleHeights[%0d]", m), moleHeights[m], 0);
		if (heightAtHit != '0) scoreModel++;
		assert (totalScore == toBcd(scoreModel))
			else reportMismatch("totalScore", totalScore, toBcd(scoreModel));
		nextDrive();
		dropOk[m] = 1'b0;
	endtask

	// **************************************************
	// checks on every cycle
	// **************************************************

	always @(posedge Clock or posedge reset) begin
		if (reset) begin
			seedModel <= '0;
			lfsrModel <= '0;
			seqModel <= '0;
		end else begin
			seedModel <= seedModel + 1'b1;
			if (loadSeed) begin
				lfsrModel <= seedModel;
			end else if (shift) begin
				lfsrModel <= {lfsrModel[0] ^ lfsrModel[2] ^ lfsrModel[3] ^ lfsrModel[5],
					lfsrModel[gamePkg::LfsrWidth-1:1]};
			end
			if (shift) seqModel <= {seqModel[gamePkg::SeqLength-2:0], lfsrModel[0]};
		end
	end

	always @(negedge Clock) begin : heightChecks
		int diff;
		if (!reset) begin
			assert (digitsValid(totalScore)) else stopWithReason("totalScore has a digit above 9");
			assert (digitsValid(totalRise)) else stopWithReason("totalRise has a digit above 9");
			for (int m = 0; m < gamePkg::NumMoles; m++) begin
				assert (moleHeights[m] <= gamePkg::HeightMax)
					else stopWithReason($sformatf("mole %0d rose above the top height", m));
				diff = int'(moleHeights[m]) - int'(prevHeights[m]);
				if (diff < 0) diff = -diff;
				if (!(dropOk[m] && moleHeights[m] == '0)) begin
					assert (diff <= 1)
						else stopWithReason($sformatf("height of mole %0d jumped by %0d", m, diff));
				end
				if (zeroPhase) begin
					assert (moleHeights[m] == '0)
						else reportMismatch($sformatf("moleHeights[%0d]", m), moleHeights[m], 0);
				end
				if (prevHeights[m] == '0 && moleHeights[m] == 1) riseSeen++; // a counted rise
			end
			prevHeights = moleHeights;
		end
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < CycleLimit) begin
			@(posedge Clock);
			cycleCount++;
		end
		$display("TEST FAILED");
		$display("run did not finish within %0d cycles", CycleLimit);
		$fatal(1);
	end

	// **************************************************
	// stimulus
	// **************************************************

	initial begin
		logic [31:0] r;
		int target;
		int playStart;
		int zeroRun;
		reset = 1'b1;
		switches = '0;
		loadSeed = 1'b0;
		shift = 1'b0;
		zeroPhase = 1'b0;
		dropOk = '0;
		prevHeights = '0;
		riseSeen = 0;
		scoreModel = 0;
		lcgState = 32'h831cd35c;
		repeat (ResetCycles) @(posedge Clock);
		#2 reset = 1'b0;

		@(negedge Clock);
		for (int m = 0; m < gamePkg::NumMoles; m++) begin
			assert (moleHeights[m] == '0)
				else reportMismatch($sformatf("moleHeights[%0d]", m), moleHeights[m], 0);
		end
		assert (totalScore == '0) else reportMismatch("totalScore", totalScore, 0);
		assert (totalRise == '0) else reportMismatch("totalRise", totalRise, 0);

		// shifting an unseeded LFSR never raises a mole
		nextDrive();
		zeroPhase = 1'b1;
		shift = 1'b1;
		repeat (ZeroPhaseCycles) nextDrive();
		zeroPhase = 1'b0;
		shift = 1'b0;

		r = nextRandom();
		repeat (1 + int'(r[31:26])) nextDrive();
		loadSeed = 1'b1;
		nextDrive();
		loadSeed = 1'b0;
		shift = 1'b1;

		playStart = cycleCount;
		while ((cycleCount - playStart) < PlayMinCycles || scoreModel < ScoreTarget) begin
			@(negedge Clock);
			r = nextRandom();
			target = pickTarget(int'(r[31:29]));
			nextDrive();
			if (target >= 0) whackHole(target);
		end

		while (!tapsClear()) nextDrive(); // stop only when no tap requests a rise
		shift = 1'b0;

		zeroRun = 0;
		while (zeroRun < 4) begin
			@(negedge Clock);
			if (moleHeights == '0) zeroRun++;
			else zeroRun = 0;
		end
		assert (totalRise == toBcd(riseSeen))
			else reportMismatch("totalRise", totalRise, toBcd(riseSeen));
		assert (totalScore == toBcd(scoreModel))
			else reportMismatch("totalScore", totalScore, toBcd(scoreModel));

		// a whack on an empty hole scores nothing
		nextDrive();
		r = nextRandom();
		whackHole(int'(r[31:29]));

		$display("TEST OK");
		$finish;
	end

endmodule

/* whackGame.f */
bcdPkg.sv
gamePkg.sv
tickGenerator.sv
moleScheduler.sv
whackDecoder.sv
moleRiser.sv
scoreTally.sv
whackGame.sv
tbWhackGame.sv

/* Bender.yml */
package:
  name: whackGame

sources:
  # packages first, then the design from the leaves up
  - bcdPkg.sv
  - gamePkg.sv
  - tickGenerator.sv
  - moleScheduler.sv
  - whackDecoder.sv
  - moleRiser.sv
  - scoreTally.sv
  - whackGame.sv
  - target: simulation
    files:
      - tbWhackGame.sv
